/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::alu_ctrl_t sel,
    output mips_pkg::word_t     y,
    output logic                zero
);
    import mips_pkg::*;

    logic less;                                              // Signed a < b

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (sel)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'b0, less};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::word_t       d_instruction,
    output mips_pkg::sel_pc_t     sel_pc,
    output mips_pkg::alu_ctrl_t   alu_ctrl,
    output logic                  sel_alu_b,
    output mips_pkg::sel_wa_t     sel_wa,
    output mips_pkg::sel_result_t sel_result,
    output logic                  rf_we,
    output logic                  mem_we
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = d_instruction[31:26];
    assign funct  = d_instruction[5:0];

    always_comb begin
        sel_pc     = SEL_PC_PLUS4;                           // Bubble unless decoded below
        alu_ctrl   = ALU_ADD;
        sel_alu_b  = 1'b1;                                   // Immediate operand
        sel_wa     = SEL_WA_RT;
        sel_result = SEL_RES_ALU;
        rf_we      = 1'b0;
        mem_we     = 1'b0;
        case (opcode)
            OPCODE_RTYPE: begin
                sel_alu_b = 1'b0;                            // rt operand
                sel_wa    = SEL_WA_RD;
                case (funct)
                    FUNCT_SUB: alu_ctrl = ALU_SUB;
                    FUNCT_AND: alu_ctrl = ALU_AND;
                    FUNCT_OR:  alu_ctrl = ALU_OR;
                    FUNCT_SLT: alu_ctrl = ALU_SLT;
                    default:   alu_ctrl = ALU_ADD;
                endcase
                rf_we  = funct inside {FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_SLT};
                sel_pc = (funct == FUNCT_JR) ? SEL_PC_REG : SEL_PC_PLUS4;
            end
            OPCODE_ADDI: rf_we = 1'b1;
            OPCODE_LW: begin
                rf_we      = 1'b1;
                sel_result = SEL_RES_MEM;
            end
            OPCODE_SW:  mem_we = 1'b1;
            OPCODE_BEQ: sel_pc = SEL_PC_BRANCH;              // Taken only if operands equal
            OPCODE_J:   sel_pc = SEL_PC_PLUS4;               // Redirect already done in fetch
            OPCODE_JAL: begin
                rf_we      = 1'b1;                           // Link write, pc+8
                sel_wa     = SEL_WA_RA;
                sel_result = SEL_RES_LINK;
            end
            default: ;                                       // Unknown, no writes
        endcase
    end

endmodule

/* datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                  clock,
    input  logic                  rst_n,
    input  mips_pkg::word_t       instruction,
    input  mips_pkg::word_t       dmem_rd,
    output logic                  dmem_we,
    output mips_pkg::word_t       pc,
    output mips_pkg::word_t       alu_out,
    output mips_pkg::word_t       dmem_wd,
    output mips_pkg::word_t       d_instruction,
    input  mips_pkg::sel_pc_t     sel_pc,
    input  mips_pkg::alu_ctrl_t   alu_ctrl,
    input  logic                  sel_alu_b,
    input  mips_pkg::sel_wa_t     sel_wa,
    input  mips_pkg::sel_result_t sel_result,
    input  logic                  rf_we,
    input  logic                  mem_we,
    input  mips_pkg::reg_addr_t   dbg_ra,
    output mips_pkg::word_t       dbg_rd
);
    import mips_pkg::*;

    word_t       pc_q, pc_next, pc_plus4, jump_addr;        // Fetch
    logic        f_jump;
    sel_pc_t     f_sel_pc;
    word_t       d_pc_plus4, d_rd0, d_rd1, d_sign_imm, branch_addr;   // Decode
    logic        d_equal, d_uses_rt, stall, bubble;
    logic        e_rf_we, e_mem_we, e_sel_alu_b;             // Execute
    alu_ctrl_t   e_alu_ctrl;
    sel_wa_t     e_sel_wa;
    sel_result_t e_sel_result;
    word_t       e_rd0, e_rd1, e_sign_imm, e_pc_plus4, e_alu_b, e_alu_y;
    reg_addr_t   e_rt, e_rd, e_wa;
    logic        m_rf_we, m_mem_we;                          // Memory
    sel_result_t m_sel_result;
    word_t       m_alu_out, m_dmem_wd, m_pc_plus4;
    reg_addr_t   m_wa, w_wa;
    logic        w_rf_we;                                    // Writeback
    sel_result_t w_sel_result;
    word_t       w_alu_out, w_dmem_rd, w_pc_plus4, w_result;

    //////////////////////////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////////////////////////

    assign pc        = pc_q;
    assign pc_plus4  = pc_q + 32'd4;
    assign f_jump    = (instruction[31:26] == OPCODE_J) || (instruction[31:26] == OPCODE_JAL);
    assign jump_addr = {pc_plus4[31:28], instruction[25:0], 2'b00};   // Region of pc+4

    always_comb begin
        if (f_jump) begin
            f_sel_pc = SEL_PC_JUMP;                          // Early jump, no slot
        end else if ((sel_pc == SEL_PC_BRANCH) && !d_equal) begin
            f_sel_pc = SEL_PC_PLUS4;                         // beq not taken
        end else begin
            f_sel_pc = sel_pc;
        end
        case (f_sel_pc)
            SEL_PC_BRANCH: pc_next = branch_addr;
            SEL_PC_JUMP:   pc_next = jump_addr;
            SEL_PC_REG:    pc_next = d_rd0;                  // jr
            default:       pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!stall) begin
            pc_q <= pc_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            d_instruction <= '0;                             // Decodes as bubble
        end else if (!stall) begin
            d_instruction <= instruction;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            d_pc_plus4 <= pc_plus4;
        end
    end

    assign d_uses_rt   = (d_instruction[31:26] == OPCODE_RTYPE)
                         || (d_instruction[31:26] == OPCODE_BEQ)
                         || (d_instruction[31:26] == OPCODE_SW);
    assign d_equal     = (d_rd0 == d_rd1);                   // beq compare
    assign d_sign_imm  = {{16{d_instruction[15]}}, d_instruction[15:0]};
    assign branch_addr = d_pc_plus4 + {d_sign_imm[29:0], 2'b00};

    regfile u_regfile (
        .clock (clock),           .rst_n (rst_n),
        .we    (w_rf_we),         .wa    (w_wa),             // From writeback
        .ra0   (d_instruction[25:21]),
        .ra1   (d_instruction[20:16]),
        .dbg_ra(dbg_ra),          .wd    (w_result),
        .rd0   (d_rd0),           .rd1   (d_rd1),
        .dbg_rd(dbg_rd)
    );

    flusher u_flusher (
        .clock  (clock),          .rst_n  (rst_n),
        .rs     (d_instruction[25:21]),
        .rt     (d_instruction[20:16]),
        .uses_rt(d_uses_rt),
        .e_wa   (e_wa),           .m_wa   (m_wa),
        .e_rf_we(e_rf_we),        .m_rf_we(m_rf_we),
        .stall  (stall),          .bubble (bubble)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            e_rf_we      <= 1'b0;
            e_mem_we     <= 1'b0;
            e_alu_ctrl   <= ALU_ADD;
            e_sel_alu_b  <= 1'b0;
            e_sel_wa     <= SEL_WA_RT;
            e_sel_result <= SEL_RES_ALU;
        end else if (bubble) begin
            e_rf_we  <= 1'b0;                                // Kill writes only
            e_mem_we <= 1'b0;
        end else begin
            e_rf_we      <= rf_we;
            e_mem_we     <= mem_we;
            e_alu_ctrl   <= alu_ctrl;
            e_sel_alu_b  <= sel_alu_b;
            e_sel_wa     <= sel_wa;
            e_sel_result <= sel_result;
        end
    end

    always_ff @(posedge clock) begin
        e_rd0      <= d_rd0;
        e_rd1      <= d_rd1;
        e_sign_imm <= d_sign_imm;
        e_rt       <= d_instruction[20:16];
        e_rd       <= d_instruction[15:11];
        e_pc_plus4 <= d_pc_plus4;
    end

    assign e_alu_b = e_sel_alu_b ? e_sign_imm : e_rd1;

    always_comb begin
        case (e_sel_wa)
            SEL_WA_RD: e_wa = e_rd;                          // R-type
            SEL_WA_RA: e_wa = REG_RA;                        // jal
            default:   e_wa = e_rt;                          // I-type
        endcase
    end

    alu u_alu (
        .a   (e_rd0),
        .b   (e_alu_b),
        .sel (e_alu_ctrl),
        .y   (e_alu_y),
        .zero()                                              // beq resolves in decode
    );

    //////////////////////////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_rf_we      <= 1'b0;
            m_mem_we     <= 1'b0;
            m_sel_result <= SEL_RES_ALU;
            w_rf_we      <= 1'b0;
            w_sel_result <= SEL_RES_ALU;
        end else begin
            m_rf_we      <= e_rf_we;
            m_mem_we     <= e_mem_we;
            m_sel_result <= e_sel_result;
            w_rf_we      <= m_rf_we;
            w_sel_result <= m_sel_result;
        end
    end

    always_ff @(posedge clock) begin
        m_alu_out  <= e_alu_y;
        m_dmem_wd  <= e_rd1;                                 // Store data is rt
        m_wa       <= e_wa;
        m_pc_plus4 <= e_pc_plus4;
        w_alu_out  <= m_alu_out;
        w_dmem_rd  <= dmem_rd;                               // Load data from RAM
        w_wa       <= m_wa;
        w_pc_plus4 <= m_pc_plus4;
    end

    assign dmem_we = m_mem_we;
    assign alu_out = m_alu_out;
    assign dmem_wd = m_dmem_wd;

    always_comb begin
        case (w_sel_result)
            SEL_RES_MEM:  w_result = w_dmem_rd;
            SEL_RES_LINK: w_result = w_pc_plus4 + 32'd4;     // jal links pc+8
            default:      w_result = w_alu_out;
        endcase
    end

endmodule

/* dmem.sv */
`timescale 1ns/1ps

module dmem (
    input  logic            clock,
    input  logic            we,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wd,
    output mips_pkg::word_t rd
);
    import mips_pkg::*;

    word_t ram [DMEM_WORDS];

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ram[i] = '0;                                     // Known contents at start
        end
    end

    always @(posedge clock) begin
        if (we) begin
            ram[addr[DMEM_AW+1:2]] <= wd;
        end
    end

    assign rd = ram[addr[DMEM_AW+1:2]];                      // Async read

    a_store_aligned : assert property (@(posedge clock) we |-> (addr[1:0] == 2'b00))
        else $error("dmem: unaligned store to %h", addr);

endmodule

/* flusher.sv */
`timescale 1ns/1ps

module flusher (
    input  logic                clock,                       // Assertion only
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rt,
    input  mips_pkg::reg_addr_t e_wa,
    input  mips_pkg::reg_addr_t m_wa,
    input  logic                e_rf_we,
    input  logic                m_rf_we,
    output logic                stall,
    output logic                bubble
);

    logic rs_hit;
    logic rt_hit;

    // Source still owed by execute or memory
    assign rs_hit = (rs != '0) && ((e_rf_we && (rs == e_wa)) || (m_rf_we && (rs == m_wa)));
    assign rt_hit = uses_rt && (rt != '0)
                    && ((e_rf_we && (rt == e_wa)) || (m_rf_we && (rt == m_wa)));

    assign stall  = rs_hit || rt_hit;                        // Hold fetch and decode
    assign bubble = stall;                                   // Flush into execute

    // Writer reaches writeback within two cycles, so the wait is bounded
    a_stall_max_2 : assert property (
        @(posedge clock) disable iff (!rst_n) stall ##1 stall |=> !stall
    ) else $error("flusher: stall held longer than 2 cycles");

endmodule

/* imem.sv */
`timescale 1ns/1ps

module imem (
    input  logic            clock,
    input  mips_pkg::word_t pc,
    output mips_pkg::word_t instruction
);
    import mips_pkg::*;

    word_t rom [IMEM_WORDS];                                 // Program storage

    initial begin
        $readmemh("program.hex", rom);
    end

    assign instruction = rom[pc[IMEM_AW+1:2]];               // Word index, async read

    // Fetch must never run off the end of the program
    a_pc_in_rom : assert property (@(posedge clock) pc[31:2] < IMEM_WORDS)
        else $error("imem: pc %h outside ROM", pc);

endmodule

/* mips_pkg.sv */
package mips_pkg;

    // Widths with a meaning
    typedef logic [31:0] word_t;                 // Data or address word
    typedef logic [4:0]  reg_addr_t;             // Register number
    typedef logic [5:0]  opcode_t;               // Instruction [31:26]
    typedef logic [5:0]  funct_t;                // R-type [5:0]

    // Opcodes
    localparam opcode_t OPCODE_RTYPE = 6'h00;
    localparam opcode_t OPCODE_J     = 6'h02;
    localparam opcode_t OPCODE_JAL   = 6'h03;
    localparam opcode_t OPCODE_BEQ   = 6'h04;
    localparam opcode_t OPCODE_ADDI  = 6'h08;
    localparam opcode_t OPCODE_LW    = 6'h23;
    localparam opcode_t OPCODE_SW    = 6'h2b;

    // R-type funct codes
    localparam funct_t FUNCT_JR  = 6'h08;
    localparam funct_t FUNCT_ADD = 6'h20;
    localparam funct_t FUNCT_SUB = 6'h22;
    localparam funct_t FUNCT_AND = 6'h24;
    localparam funct_t FUNCT_OR  = 6'h25;
    localparam funct_t FUNCT_SLT = 6'h2a;

    localparam reg_addr_t REG_RA = 5'd31;        // Link register

    // Memory depths in words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        SEL_PC_PLUS4, SEL_PC_BRANCH, SEL_PC_JUMP, SEL_PC_REG
    } sel_pc_t;

    typedef enum logic [1:0] {
        SEL_WA_RT, SEL_WA_RD, SEL_WA_RA
    } sel_wa_t;

    typedef enum logic [1:0] {
        SEL_RES_MEM, SEL_RES_ALU, SEL_RES_LINK
    } sel_result_t;

endpackage

/* mips_top.sv */
`timescale 1ns/1ps

module mips_top (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t dbg_ra,
    output mips_pkg::word_t     dbg_rd,
    output mips_pkg::word_t     pc,
    output logic                dmem_we,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wd
);
    import mips_pkg::*;

    word_t       instruction, d_instruction, dmem_rd;
    sel_pc_t     sel_pc;
    alu_ctrl_t   alu_ctrl;
    logic        sel_alu_b;
    sel_wa_t     sel_wa;
    sel_result_t sel_result;
    logic        rf_we;
    logic        mem_we;

    imem u_imem (
        .clock      (clock),
        .pc         (pc),
        .instruction(instruction)
    );

    control_unit u_control_unit (.*);                        // Decodes d_instruction

    datapath u_datapath (
        .alu_out(dmem_addr),                                 // Memory stage address
        .*
    );

    dmem u_dmem (
        .clock(clock),
        .we   (dmem_we),
        .addr (dmem_addr),
        .wd   (dmem_wd),
        .rd   (dmem_rd)
    );

endmodule

/* program.hex */
// One instruction word per line, word address = line index, byte address = 4 * index
// word      index  instruction
2001000C  // 00  addi $1, $0, 12
2002FFFD  // 01  addi $2, $0, -3
00221820  // 02  add  $3, $1, $2
00432022  // 03  sub  $4, $2, $3
00812824  // 04  and  $5, $4, $1
00A33025  // 05  or   $6, $5, $3
0086382A  // 06  slt  $7, $4, $6
00C4402A  // 07  slt  $8, $6, $4
AC060008  // 08  sw   $6, 8($0)
AC24000C  // 09  sw   $4, 12($1)
8C090008  // 10  lw   $9, 8($0)
8C0A0018  // 11  lw   $10, 24($0)
01495820  // 12  add  $11, $10, $9
2000004D  // 13  addi $0, $0, 77
00036020  // 14  add  $12, $0, $3
11260002  // 15  beq  $9, $6, +2
200D0011  // 16  addi $13, $0, 0x11
200E0022  // 17  addi $14, $0, 0x22
10220002  // 18  beq  $1, $2, +2
200F0033  // 19  addi $15, $0, 0x33
20100044  // 20  addi $16, $0, 0x44
0C000019  // 21  jal  25
20110055  // 22  addi $17, $0, 0x55
20120066  // 23  addi $18, $0, 0x66
08000018  // 24  j    24
20130077  // 25  addi $19, $0, 0x77
03E00008  // 26  jr   $31
20140088  // 27  addi $20, $0, 0x88
20150099  // 28  addi $21, $0, 0x99

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::reg_addr_t ra0,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t dbg_ra,
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd0,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     dbg_rd
);
    import mips_pkg::*;

    word_t regs [1:31];                                      // No storage for r0

    // Zero for r0, write data when the same register is written this cycle
    function automatic word_t read_port(input reg_addr_t ra);
        if (ra == '0) begin
            return '0;
        end
        if (we && (ra == wa)) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd0    = read_port(ra0);
        rd1    = read_port(ra1);
        dbg_rd = read_port(dbg_ra);                          // Testbench peek
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;                                  // Writes to r0 dropped
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mips \
    -f sources.f -o tb_mips
./obj_dir/tb_mips | tee sim.log

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

/* sources.f */
mips_pkg.sv
imem.sv
control_unit.sv
regfile.sv
alu.sv
flusher.sv
datapath.sv
dmem.sv
mips_top.sv
tb_mips.sv

/* tb_mips.sv */
`timescale 1ns/1ps

module tb_mips;
    import mips_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    PROG_WORDS   = 29;                     // Words in program.hex
    localparam int    WATCHDOG_NS  = 200 * PROG_WORDS * CLK_PERIOD;
    localparam int    DRAIN_CYCLES = 6;                      // Let the last writes retire
    localparam int    NUM_STORES   = 2;
    localparam word_t END_PC       = 32'h0000_0060;          // Self-loop j at index 24
    localparam word_t JAL_PC       = 32'h0000_0054;          // jal at index 21

    // Register groups per behavior
    localparam logic [31:0] ALU_MASK   = 32'h0000_01FE;      // r1..r8
    localparam logic [31:0] CHAIN_MASK = 32'h0000_09F8;      // r3..r8, r11
    localparam logic [31:0] MEM_MASK   = 32'h0000_0E00;      // r9..r11
    localparam logic [31:0] FLOW_MASK  = 32'h803F_E000;      // r13..r21, r31
    localparam logic [31:0] ZERO_MASK  = 32'h0000_1001;      // r0, r12

    logic      clock;
    logic      rst_n;
    reg_addr_t dbg_ra;
    word_t     dbg_rd;
    word_t     pc;
    logic      dmem_we;
    word_t     dmem_addr;
    word_t     dmem_wd;

    int    mismatches = 0;
    int    failures   = 0;
    int    store_idx  = 0;                                   // Next expected store
    int    seed_val;
    word_t exp_reg  [32];
    word_t exp_addr [NUM_STORES];
    word_t exp_data [NUM_STORES];

    mips_top dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .dbg_ra   (dbg_ra),
        .dbg_rd   (dbg_rd),
        .pc       (pc),
        .dmem_we  (dmem_we),
        .dmem_addr(dmem_addr),
        .dmem_wd  (dmem_wd)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and reference values
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ISA slt on two's complement words, 1 when a is below b
    function automatic word_t slt_of(input word_t a, input word_t b);
        word_t diff;
        diff = a - b;
        if (a[31] != b[31]) begin
            return {31'b0, a[31]};                           // Negative operand is the lower one
        end
        return {31'b0, diff[31]};                            // Same sign so a - b cannot overflow
    endfunction

    // Architectural state that the ISA gives for the program's constants
    task automatic compute_expected();
        foreach (exp_reg[r]) begin
            exp_reg[r] = '0;                                 // Untouched registers stay clear
        end
        exp_reg[1]  = 32'd12;
        exp_reg[2]  = word_t'(-3);                           // Sign-extended immediate
        exp_reg[3]  = exp_reg[1] + exp_reg[2];
        exp_reg[4]  = exp_reg[2] - exp_reg[3];
        exp_reg[5]  = exp_reg[4] & exp_reg[1];
        exp_reg[6]  = exp_reg[5] | exp_reg[3];
        exp_reg[7]  = slt_of(exp_reg[4], exp_reg[6]);       // Negative operand
        exp_reg[8]  = slt_of(exp_reg[6], exp_reg[4]);
        exp_addr[0] = 32'd0 + 32'd8;                         // sw $6, 8($0)
        exp_data[0] = exp_reg[6];
        exp_addr[1] = exp_reg[1] + 32'd12;                   // sw $4, 12($1)
        exp_data[1] = exp_reg[4];
        exp_reg[9]  = exp_data[0];                           // lw from 8
        exp_reg[10] = exp_data[1];                           // lw from 24
        exp_reg[11] = exp_reg[10] + exp_reg[9];              // Load-use chain
        exp_reg[12] = exp_reg[3];                            // r0 + r3
        exp_reg[13] = 32'h11;                                // beq delay slot runs
        exp_reg[15] = 32'h33;                                // Not-taken slot
        exp_reg[16] = 32'h44;                                // Fall-through
        exp_reg[18] = 32'h66;                                // After return
        exp_reg[19] = 32'h77;                                // Subroutine body
        exp_reg[20] = 32'h88;                                // jr delay slot
        exp_reg[31] = JAL_PC + 32'd8;                        // Link value
    endtask

    //////////////////////////////////////////////////////////////////////
    // Store monitor for each dmem write in program order
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (rst_n && (dmem_we === 1'b1)) begin
            if (store_idx >= NUM_STORES) begin
                failures++;
                $display("Unexpected extra store to %h at %0t ns", dmem_addr, $time);
            end else begin
                check_word("dmem_addr", dmem_addr, exp_addr[store_idx]);
                check_word("dmem_wd", dmem_wd, exp_data[store_idx]);
                store_idx++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers and directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic read_reg(input reg_addr_t r, output word_t value);
        @(posedge clock);
        #1 dbg_ra = r;
        @(negedge clock);
        value = dbg_rd;                                      // Settled mid-cycle
    endtask

    // Reads each register in the mask in fixed or shuffled order
    task automatic verify_registers(input logic [31:0] mask, input bit shuffle);
        reg_addr_t order[$];
        reg_addr_t tmp;
        word_t     value;
        int        j;
        for (int r = 0; r < 32; r++) begin
            if (mask[r]) begin
                order.push_back(reg_addr_t'(r));
            end
        end
        if (shuffle) begin
            for (int i = order.size() - 1; i > 0; i--) begin
                j = $urandom_range(i, 0);                    // Fisher-Yates swap
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        foreach (order[k]) begin
            read_reg(order[k], value);
            check_word($sformatf("dbg_rd[r%0d]", order[k]), value, exp_reg[order[k]]);
        end
    endtask

    task automatic reset_sequence();
        repeat (3) begin
            @(posedge clock);
            #1;
            check_word("pc", pc, RESET_PC);
            check_bit("dmem_we", dmem_we, 1'b0);
        end
        rst_n = 1'b1;                                        // 1 ns after third edge
        @(negedge clock);
        check_word("pc", pc, RESET_PC);                      // First cycle out of reset
        check_bit("dmem_we", dmem_we, 1'b0);
    endtask

    task automatic wait_for_end();
        while (pc !== END_PC) begin
            @(negedge clock);                                // Poll once per cycle
        end
        repeat (DRAIN_CYCLES) @(negedge clock);
    endtask

    task automatic alu_results();
        verify_registers(ALU_MASK, 1'b0);
    endtask

    task automatic dependence_chains();
        verify_registers(CHAIN_MASK, 1'b1);                  // Random read order
    endtask

    task automatic stores_and_loads();
        if (store_idx != NUM_STORES) begin
            failures++;
            $display("Expected %0d stores but saw %0d", NUM_STORES, store_idx);
        end
        verify_registers(MEM_MASK, 1'b0);
    endtask

    task automatic control_flow();
        verify_registers(FLOW_MASK, 1'b0);                   // r14, r17, r21 stay zero
    endtask

    task automatic register_zero();
        verify_registers(ZERO_MASK, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed_val = $urandom(63);                             // Seed once
        rst_n    = 1'b0;
        dbg_ra   = '0;
        compute_expected();
        reset_sequence();
        wait_for_end();
        alu_results();
        dependence_chains();
        stores_and_loads();
        control_flow();
        register_zero();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        failures++;
        $display("Timeout after %0d ns, program never reached its end loop", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Something failed");
        $finish;
    end

endmodule
